// File: hw/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// axi-lite bus widths, one word per beat
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// one strobe bit per data byte
`define AXI_STRB_W 4

// okay / slverr encoding fits in two bits
`define AXI_RESP_W 2

// instruction sram size in 32-bit words
// byte addresses 0 .. 4*depth-1 are valid
`define ISRAM_DEPTH 256

// cycles from ar handshake to rvalid
`define ISRAM_LATENCY 3

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
// shown on rdata when idle and returned with error responses
`define INST_NOP 32'h0000_0013

`endif

// File: hw/fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    // axi-lite response codes
    // exokay and decerr never produced here
    typedef enum logic [`AXI_RESP_W-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // instruction sram slave states
    typedef enum logic [1:0] {
        ISRAM_IDLE,
        ISRAM_READ,
        ISRAM_WRESP
    } isram_state_e;

    // fetch unit states
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_WAIT,
        FETCH_HALT
    } fetch_state_e;

endpackage

`default_nettype wire

// File: hw/isram.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module isram
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // read address
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    // read data
    output logic [`AXI_DATA_W-1:0] rdata,
    output logic [`AXI_RESP_W-1:0] rresp,
    output logic                   rvalid,
    input  logic                   rready,
    // write address
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    // write data
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic [`AXI_STRB_W-1:0] wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    // write response
    output logic [`AXI_RESP_W-1:0] bresp,
    output logic                   bvalid,
    input  logic                   bready
);

    localparam int IDX_W = $clog2(`ISRAM_DEPTH);
    localparam int CNT_W = $clog2(`ISRAM_LATENCY + 1);

    isram_state_e state;
    isram_state_e next_state;

    // word array with byte lanes written under strobes
    logic [`AXI_DATA_W-1:0] mem [`ISRAM_DEPTH];

    logic [`AXI_ADDR_W-1:0] rd_addr;
    logic [CNT_W-1:0]       lat_cnt;
    logic                   data_valid;
    logic [`AXI_DATA_W-1:0] rdata_q;
    axi_resp_e              rresp_q;
    axi_resp_e              bresp_q;

    logic ar_hs;
    logic r_hs;
    logic b_hs;
    logic wr_accept;
    logic rd_ok;
    logic wr_ok;

    // word aligned and inside the array
    function automatic logic addr_ok(input logic [`AXI_ADDR_W-1:0] addr);
        logic aligned;
        logic in_range;
        aligned  = (addr[1:0] == 2'b00);
        in_range = (addr < `AXI_ADDR_W'(`ISRAM_DEPTH * 4));
        return aligned && in_range;
    endfunction

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;
    assign b_hs  = bvalid && bready;

    // address and data taken together
    // reads win
    assign wr_accept = (state == ISRAM_IDLE) && awvalid && wvalid && !arvalid;

    assign rd_ok = addr_ok(rd_addr);
    assign wr_ok = addr_ok(awaddr);

    assign arready = (state == ISRAM_IDLE);
    assign awready = wr_accept;
    assign wready  = wr_accept;

    assign rvalid = data_valid;
    // nop on the bus whenever nothing valid is shown
    assign rdata  = rvalid ? rdata_q : `INST_NOP;
    assign rresp  = rvalid ? rresp_q : RESP_OKAY;

    assign bvalid = (state == ISRAM_WRESP);
    assign bresp  = bresp_q;

    always_comb begin
        next_state = state;
        case (state)
            ISRAM_IDLE: begin
                if (ar_hs) begin
                    next_state = ISRAM_READ;
                end else if (wr_accept) begin
                    next_state = ISRAM_WRESP;
                end
            end
            ISRAM_READ: begin
                if (r_hs) begin
                    next_state = ISRAM_IDLE;
                end
            end
            ISRAM_WRESP: begin
                if (b_hs) begin
                    next_state = ISRAM_IDLE;
                end
            end
            default: begin
                next_state = ISRAM_IDLE;
            end
        endcase
    end

    // fsm, latency counter and data valid flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ISRAM_IDLE;
            lat_cnt    <= '0;
            data_valid <= 1'b0;
        end else begin
            state <= next_state;
            if (ar_hs) begin
                // counts down to zero and the word shows up on the next edge
                lat_cnt    <= CNT_W'(`ISRAM_LATENCY - 1);
                data_valid <= 1'b0;
            end else if (state == ISRAM_READ && !data_valid) begin
                if (lat_cnt == '0) begin
                    data_valid <= 1'b1;
                end else begin
                    lat_cnt <= lat_cnt - 1'b1;
                end
            end else if (r_hs) begin
                data_valid <= 1'b0;
            end
        end
    end

    // read address capture
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_addr <= araddr;
        end
    end

    // read data register loaded once when the delay runs out
    always_ff @(posedge clk) begin
        if (state == ISRAM_READ && !data_valid && lat_cnt == '0) begin
            if (rd_ok) begin
                rdata_q <= mem[rd_addr[IDX_W+1:2]];
                rresp_q <= RESP_OKAY;
            end else begin
                rdata_q <= `INST_NOP;
                rresp_q <= RESP_SLVERR;
            end
        end
    end

    // byte lane writes
    // a bad address leaves the array alone
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            if (wr_ok) begin
                for (int i = 0; i < `AXI_STRB_W; i++) begin
                    if (wstrb[i]) begin
                        mem[awaddr[IDX_W+1:2]][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    // valid data only while a read is being answered
    a_rvalid_in_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid |-> state == ISRAM_READ
    );

    // held response stays put until the master takes it
    a_r_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

`default_nettype wire

// File: hw/ifu.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module ifu
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_en,
    input  logic                   redirect_valid,
    input  logic [`AXI_ADDR_W-1:0] redirect_pc,
    // read address
    output logic [`AXI_ADDR_W-1:0] araddr,
    output logic                   arvalid,
    input  logic                   arready,
    // read data
    input  logic [`AXI_DATA_W-1:0] rdata,
    input  logic [`AXI_RESP_W-1:0] rresp,
    input  logic                   rvalid,
    output logic                   rready,
    // decode slot
    output logic [`AXI_DATA_W-1:0] inst,
    output logic [`AXI_ADDR_W-1:0] inst_pc,
    output logic                   inst_err,
    output logic                   inst_valid,
    input  logic                   inst_ready
);

    fetch_state_e state;

    logic [`AXI_ADDR_W-1:0] pc;
    logic [`AXI_ADDR_W-1:0] req_pc;
    // response still in flight belongs to the old stream
    logic discard;

    logic ar_hs;
    logic r_hs;
    logic issue;
    logic take;
    logic take_err;
    logic outstanding;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // a redirect in the issue cycle goes straight onto the bus
    assign req_pc = redirect_valid ? redirect_pc : pc;
    assign issue  = (state == FETCH_ADDR) && !arvalid && fetch_en;

    // slot empty or draining, or the word gets dropped anyway
    assign rready = (state == FETCH_WAIT) && (discard || !inst_valid || inst_ready);

    // response kept only when no redirect killed it
    assign take     = r_hs && !discard && !redirect_valid;
    assign take_err = take && (rresp != RESP_OKAY);

    // a read is still owed by the sram after this edge
    assign outstanding = arvalid || (state == FETCH_WAIT && !r_hs);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= FETCH_IDLE;
            pc         <= `RESET_PC;
            arvalid    <= 1'b0;
            discard    <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            // output slot
            if (redirect_valid) begin
                inst_valid <= 1'b0;
            end else if (take) begin
                inst_valid <= 1'b1;
            end else if (inst_ready) begin
                inst_valid <= 1'b0;
            end

            // read address valid, held until accepted
            if (ar_hs) begin
                arvalid <= 1'b0;
            end else if (issue) begin
                arvalid <= 1'b1;
            end

            if (redirect_valid && outstanding) begin
                discard <= 1'b1;
            end else if (r_hs) begin
                discard <= 1'b0;
            end

            // pc only moves on a good word
            if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (take && !take_err) begin
                pc <= pc + 32'd4;
            end

            case (state)
                FETCH_IDLE: begin
                    if (fetch_en) begin
                        state <= FETCH_ADDR;
                    end
                end
                FETCH_ADDR: begin
                    if (ar_hs) begin
                        state <= FETCH_WAIT;
                    end else if (!arvalid && !fetch_en) begin
                        state <= FETCH_IDLE;
                    end
                end
                FETCH_WAIT: begin
                    if (take_err) begin
                        state <= FETCH_HALT;
                    end else if (r_hs) begin
                        state <= FETCH_ADDR;
                    end
                end
                FETCH_HALT: begin
                    // only a redirect restarts
                    if (redirect_valid) begin
                        state <= FETCH_ADDR;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // request address
    always_ff @(posedge clk) begin
        if (issue) begin
            araddr <= req_pc;
        end
    end

    // decode payload, tagged with the address that was read
    always_ff @(posedge clk) begin
        if (take) begin
            inst     <= rdata;
            inst_pc  <= araddr;
            inst_err <= take_err;
        end
    end

    // request stays on the bus unchanged until the sram takes it
    a_ar_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_en,
    input  logic                   redirect_valid,
    input  logic [`AXI_ADDR_W-1:0] redirect_pc,
    // loader write channels, straight to the sram
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic [`AXI_STRB_W-1:0] wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [`AXI_RESP_W-1:0] bresp,
    output logic                   bvalid,
    input  logic                   bready,
    // decode slot
    output logic [`AXI_DATA_W-1:0] inst,
    output logic [`AXI_ADDR_W-1:0] inst_pc,
    output logic                   inst_err,
    output logic                   inst_valid,
    input  logic                   inst_ready
);

    // internal read channel, fetch unit is the only master
    logic [`AXI_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [`AXI_DATA_W-1:0] rdata;
    logic [`AXI_RESP_W-1:0] rresp;
    logic                   rvalid;
    logic                   rready;

    ifu ifu_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_en       (fetch_en),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .inst_err       (inst_err),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready)
    );

    isram isram_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held low for three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int LOAD_WORDS  = 64;
    localparam int SEQ_COUNT   = 24;
    localparam int REDIR_COUNT = 16;
    localparam int TAIL_COUNT  = 8;
    localparam int HALT_CYCLES = 20;
    // program words, three strobed rewrites, two rejected writes
    localparam int LOAD_WRITES = LOAD_WORDS + 5;
    // the two error fetches count as planned fetches too
    localparam int FETCHES     = SEQ_COUNT + REDIR_COUNT + TAIL_COUNT + 2;
    localparam int TIMEOUT_CYCLES = FETCHES * (`ISRAM_LATENCY + 10)
                                  + LOAD_WRITES * 8 + 2 * HALT_CYCLES + 50;

    logic                   clk;
    logic                   rst_n;
    logic                   fetch_en;
    logic                   redirect_valid;
    logic [`AXI_ADDR_W-1:0] redirect_pc;
    logic [`AXI_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [`AXI_DATA_W-1:0] wdata;
    logic [`AXI_STRB_W-1:0] wstrb;
    logic                   wvalid;
    logic                   wready;
    logic [`AXI_RESP_W-1:0] bresp;
    logic                   bvalid;
    logic                   bready;
    logic [`AXI_DATA_W-1:0] inst;
    logic [`AXI_ADDR_W-1:0] inst_pc;
    logic                   inst_err;
    logic                   inst_valid;
    logic                   inst_ready;

    integer seed = 32'h6ffb_ce8f;
    int     errors = 0;
    // both counters move on clock edges only, nba updates
    int     delivered = 0;
    int     err_seen = 0;

    // reference copy of the sram contents
    logic [`AXI_DATA_W-1:0] ref_mem [`ISRAM_DEPTH];
    logic [`AXI_ADDR_W-1:0] exp_pc;
    logic                   halted;

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_top fetch_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_en       (fetch_en),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wvalid         (wvalid),
        .wready         (wready),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .inst_err       (inst_err),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready)
    );

    // aligned and below depth*4
    function automatic logic word_addr_ok(input logic [`AXI_ADDR_W-1:0] addr);
        return (addr[1:0] == 2'b00) && (addr < `ISRAM_DEPTH * 4);
    endfunction

    // word and error flag a fetch from pc should give
    function automatic void expected_fetch(input  logic [`AXI_ADDR_W-1:0] pc,
                                           output logic [`AXI_DATA_W-1:0] word,
                                           output logic                   err);
        if (word_addr_ok(pc)) begin
            word = ref_mem[pc >> 2];
            err  = 1'b0;
        end else begin
            word = `INST_NOP;
            err  = 1'b1;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one loader write, address and data together
    task automatic load_word(input logic [`AXI_ADDR_W-1:0] addr,
                             input logic [`AXI_DATA_W-1:0] data,
                             input logic [`AXI_STRB_W-1:0] strb);
        axi_resp_e exp_resp;
        exp_resp = word_addr_ok(addr) ? RESP_OKAY : RESP_SLVERR;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        do @(posedge clk); while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk); while (!bvalid);
        bready <= 1'b0;
        check_value("bresp", exp_resp, bresp);
        if (exp_resp == RESP_OKAY) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (strb[i]) begin
                    ref_mem[addr >> 2][8*i +: 8] = data[8*i +: 8];
                end
            end
        end
    endtask

    // random decode back-pressure until enough words came out
    task automatic stream_until(input int target);
        logic [31:0] rnd;
        while (delivered < target) begin
            @(posedge clk);
            rnd = $random(seed);
            inst_ready <= rnd[0];
        end
    endtask

    task automatic stream_until_error(input int target);
        logic [31:0] rnd;
        while (err_seen < target) begin
            @(posedge clk);
            rnd = $random(seed);
            inst_ready <= rnd[0];
        end
    endtask

    task automatic random_cycles(input int n);
        logic [31:0] rnd;
        repeat (n) begin
            @(posedge clk);
            rnd = $random(seed);
            inst_ready <= rnd[0];
        end
    endtask

    // redirect pulse, exactly one cycle
    task automatic redirect_to(input logic [`AXI_ADDR_W-1:0] pc);
        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_pc    <= pc;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    // checks every decode handshake against the reference
    always @(posedge clk) begin : compare_decode
        logic [`AXI_DATA_W-1:0] exp_word;
        logic                   exp_err;
        if (!rst_n) begin
            exp_pc <= `RESET_PC;
            halted <= 1'b0;
        end else begin
            if (inst_valid && inst_ready) begin
                if (halted) begin
                    errors++;
                    $display("instruction at pc %h delivered while fetch should be halted",
                             inst_pc);
                end
                expected_fetch(exp_pc, exp_word, exp_err);
                check_value("inst_pc", exp_pc, inst_pc);
                check_value("inst", exp_word, inst);
                check_value("inst_err", exp_err, inst_err);
                delivered <= delivered + 1;
                if (exp_err) begin
                    halted   <= 1'b1;
                    err_seen <= err_seen + 1;
                end else begin
                    exp_pc <= exp_pc + 32'd4;
                end
            end
            // redirect wins over the increment above
            if (redirect_valid) begin
                exp_pc <= redirect_pc;
                halted <= 1'b0;
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        int          idx;
        fetch_en       = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wstrb          = '0;
        wvalid         = 1'b0;
        bready         = 1'b0;
        inst_ready     = 1'b0;
        while (rst_n !== 1'b1) @(posedge clk);

        // program load, fetch unit idle so writes are not blocked
        for (int i = 0; i < LOAD_WORDS; i++) begin
            rnd = $random(seed);
            load_word(i * 4, rnd, 4'hf);
        end
        // partial strobe rewrites
        rnd = $random(seed);
        load_word(32'd12, rnd, 4'b0001);
        rnd = $random(seed);
        load_word(32'd40, rnd, 4'b0110);
        rnd = $random(seed);
        load_word(32'd68, rnd, 4'b1100);
        // rejected writes, array must stay as it is
        load_word(32'h0000_0400, 32'hdead_beef, 4'hf);
        load_word(32'h0000_0006, 32'hdead_beef, 4'hf);

        // sequential stream from reset pc
        fetch_en <= 1'b1;
        stream_until(SEQ_COUNT);

        // mid-stream redirect, target leaves room inside the loaded words
        rnd = $random(seed);
        idx = 24 + (rnd[7:0] % 16);
        redirect_to(idx * 4);
        stream_until(delivered + REDIR_COUNT);

        // misaligned target then one past the end
        redirect_to(32'h0000_0102);
        stream_until_error(1);
        random_cycles(HALT_CYCLES);
        redirect_to(32'h0000_0400);
        stream_until_error(2);
        random_cycles(HALT_CYCLES);

        // restart after the halt
        rnd = $random(seed);
        idx = rnd[7:0] % 48;
        redirect_to(idx * 4);
        stream_until(delivered + TAIL_COUNT);

        @(posedge clk);
        fetch_en   <= 1'b0;
        inst_ready <= 1'b1;
        repeat (`ISRAM_LATENCY + 8) @(posedge clk);

        $display("fetch_tb: %0d instructions checked, %0d errors", delivered, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles, %0d instructions delivered",
                 TIMEOUT_CYCLES, delivered);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/fetch_pkg.sv
hw/isram.sv
hw/ifu.sv
hw/fetch_top.sv
dv/tb_clock.sv
dv/fetch_tb.sv
